// ==== common/eu_params.svh ====
// ----------------------------------------------------------
// event unit parameters
// widths, core count and software event count
// ----------------------------------------------------------

`ifndef EU_PARAMS_SVH
`define EU_PARAMS_SVH

// bus data width, also the number of event lines
`define EU_DATA_W 32

// word offset width of the register port
`define EU_ADDR_W 5

// cores reachable by a software event
`define EU_NB_CORES 4

// software event lines
`define EU_NB_SW_EVT 8

// interrupt id width
`define EU_IRQ_ID_W 5

`endif

// ==== common/eu_pkg.sv ====
// ----------------------------------------------------------
// event unit package
// register map, decoded operations and sleep state
// ----------------------------------------------------------

`include "eu_params.svh"

package eu_pkg;

  // word offsets of the register port
  typedef enum logic [`EU_ADDR_W-1:0] {
    REG_EVT_MASK          = 5'd0,
    REG_EVT_MASK_AND      = 5'd1,
    REG_EVT_MASK_OR       = 5'd2,
    REG_IRQ_MASK          = 5'd3,
    REG_IRQ_MASK_AND      = 5'd4,
    REG_IRQ_MASK_OR       = 5'd5,
    REG_EVT_BUFFER        = 5'd7,
    REG_EVT_BUFFER_MASKED = 5'd8,
    REG_EVT_BUFFER_IRQ    = 5'd9,
    REG_BUFFER_CLEAR      = 5'd10,
    REG_SW_EVT_MASK       = 5'd11,
    REG_EVT_WAIT          = 5'd14,
    REG_EVT_WAIT_CLEAR    = 5'd15,
    REG_SW_EVT_TRIG0      = 5'd16,
    REG_SW_EVT_TRIG7      = 5'd23
  } eu_reg_e;

  // operation decoded from offset and write flag
  typedef enum logic [3:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE,
    OP_AND,
    OP_OR,
    OP_BUF_CLEAR,
    OP_SW_TRIG,
    OP_WAIT,
    OP_WAIT_CLEAR
  } eu_op_e;

  // core clock controller state
  typedef enum logic {
    AWAKE,
    ASLEEP
  } eu_sleep_e;

endpackage

// ==== common/eu_op_if.sv ====
// ----------------------------------------------------------
// decoded operation link
// carries one accepted access from decode to the register bank
// ----------------------------------------------------------

`include "eu_params.svh"

interface eu_op_if;

  // one cycle per accepted request
  logic                              fire;
  eu_pkg::eu_op_e                    op;
  eu_pkg::eu_reg_e                   reg_sel;
  logic [$clog2(`EU_NB_SW_EVT)-1:0]  sw_idx;
  logic [`EU_DATA_W-1:0]             wdata;

  // read value of the current op, combinational
  logic [`EU_DATA_W-1:0]             rdata;

  modport dec (
    output fire,
    output op,
    output reg_sel,
    output sw_idx,
    output wdata
  );

  modport exe (
    input  fire,
    input  op,
    input  reg_sel,
    input  sw_idx,
    input  wdata,
    output rdata
  );

  modport res (
    input  fire,
    input  rdata
  );

endinterface

// ==== hw/eu_core/eu_req_decode.sv ====
// ----------------------------------------------------------
// event unit request decode
// accepts bus requests and holds back waits until an event
// ----------------------------------------------------------

`include "eu_params.svh"

module eu_req_decode (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic [`EU_ADDR_W-1:0] req_addr_i,
  input  logic                  req_we_i,
  input  logic [`EU_DATA_W-1:0] req_wdata_i,

  input  logic                  evt_pending_i,
  input  logic                  irq_pending_i,
  input  logic                  resp_busy_i,
  output logic                  wait_blocked_o,

  eu_op_if.dec                  op_o
);

  eu_pkg::eu_reg_e reg_sel;
  eu_pkg::eu_op_e  op;
  logic            is_wait;
  logic            wait_ok;
  logic            wait_blocked_q;

  assign reg_sel = eu_pkg::eu_reg_e'(req_addr_i);

  // offset and write flag to operation
  always_comb begin
    op = eu_pkg::OP_NONE;
    if (req_we_i) begin
      case (reg_sel)
        eu_pkg::REG_EVT_MASK,
        eu_pkg::REG_IRQ_MASK,
        eu_pkg::REG_SW_EVT_MASK:  op = eu_pkg::OP_WRITE;
        eu_pkg::REG_EVT_MASK_AND,
        eu_pkg::REG_IRQ_MASK_AND: op = eu_pkg::OP_AND;
        eu_pkg::REG_EVT_MASK_OR,
        eu_pkg::REG_IRQ_MASK_OR:  op = eu_pkg::OP_OR;
        eu_pkg::REG_BUFFER_CLEAR: op = eu_pkg::OP_BUF_CLEAR;
        default: begin
          // trigger window covers offsets 16 to 23
          if (req_addr_i inside {[eu_pkg::REG_SW_EVT_TRIG0 : eu_pkg::REG_SW_EVT_TRIG7]}) begin
            op = eu_pkg::OP_SW_TRIG;
          end
        end
      endcase
    end else begin
      case (reg_sel)
        eu_pkg::REG_EVT_WAIT:       op = eu_pkg::OP_WAIT;
        eu_pkg::REG_EVT_WAIT_CLEAR: op = eu_pkg::OP_WAIT_CLEAR;
        default:                    op = eu_pkg::OP_READ;
      endcase
    end
  end

  assign is_wait = (op == eu_pkg::OP_WAIT) || (op == eu_pkg::OP_WAIT_CLEAR);

  // a wait only goes through with a masked event and no interrupt pending
  assign wait_ok = evt_pending_i & ~irq_pending_i;

  assign req_ready_o = ~resp_busy_i & (~is_wait | wait_ok);

  assign op_o.fire    = req_valid_i & req_ready_o;
  assign op_o.op      = op;
  assign op_o.reg_sel = reg_sel;
  assign op_o.sw_idx  = req_addr_i[$clog2(`EU_NB_SW_EVT)-1:0];
  assign op_o.wdata   = req_wdata_i;

  // wait presented but not taken this cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_blocked_q <= 1'b0;
    end else begin
      wait_blocked_q <= req_valid_i & is_wait & ~req_ready_o;
    end
  end

  assign wait_blocked_o = wait_blocked_q;

endmodule

// ==== hw/eu_core/eu_event_regs.sv ====
// ----------------------------------------------------------
// event unit register bank
// masks, event buffer, interrupt selection, software events
// ----------------------------------------------------------

`include "eu_params.svh"

module eu_event_regs (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  logic [`EU_DATA_W-1:0]    evt_lines_i,
  input  logic                     core_irq_ack_i,
  input  logic [`EU_IRQ_ID_W-1:0]  core_irq_ack_id_i,

  eu_op_if.exe                     op_i,

  output logic                     evt_pending_o,
  output logic                     irq_pending_o,
  output logic                     core_irq_req_o,
  output logic [`EU_IRQ_ID_W-1:0]  core_irq_id_o,
  output logic [`EU_NB_SW_EVT-1:0] core_sw_events_o,
  output logic [`EU_NB_CORES-1:0]  core_sw_events_mask_o
);

  logic [`EU_DATA_W-1:0]    evt_mask_q;
  logic [`EU_DATA_W-1:0]    irq_mask_q;
  logic [`EU_DATA_W-1:0]    buffer_q;
  logic [`EU_DATA_W-1:0]    buffer_d;
  logic [`EU_NB_CORES-1:0]  sw_mask_q;
  logic [`EU_DATA_W-1:0]    evt_masked;
  logic [`EU_DATA_W-1:0]    irq_masked;
  logic [`EU_DATA_W-1:0]    ack_keep;
  logic                     irq_req_q;
  logic [`EU_NB_SW_EVT-1:0] sw_evt_q;
  logic [`EU_NB_CORES-1:0]  sw_evt_mask_q;
  logic                     evt_mask_we;
  logic                     irq_mask_we;
  logic                     sw_trig;
  logic [`EU_NB_CORES-1:0]  trig_cores;

  // plain write, and-clear or or-set
  function automatic logic [`EU_DATA_W-1:0] mask_upd(
    input logic [`EU_DATA_W-1:0] old_val,
    input logic [`EU_DATA_W-1:0] wdata,
    input eu_pkg::eu_op_e        op
  );
    case (op)
      eu_pkg::OP_WRITE: return wdata;
      eu_pkg::OP_AND:   return old_val & ~wdata;
      eu_pkg::OP_OR:    return old_val | wdata;
      default:          return old_val;
    endcase
  endfunction

  assign evt_masked    = buffer_q & evt_mask_q;
  assign irq_masked    = buffer_q & irq_mask_q;
  assign evt_pending_o = |evt_masked;
  assign irq_pending_o = |irq_masked;

  assign evt_mask_we = op_i.fire && (op_i.reg_sel inside {eu_pkg::REG_EVT_MASK,
                       eu_pkg::REG_EVT_MASK_AND, eu_pkg::REG_EVT_MASK_OR});
  assign irq_mask_we = op_i.fire && (op_i.reg_sel inside {eu_pkg::REG_IRQ_MASK,
                       eu_pkg::REG_IRQ_MASK_AND, eu_pkg::REG_IRQ_MASK_OR});
  assign sw_trig     = op_i.fire && (op_i.op == eu_pkg::OP_SW_TRIG);

  // zero core bits address every core
  assign trig_cores = (op_i.wdata[`EU_NB_CORES-1:0] == '0) ? '1 :
                      op_i.wdata[`EU_NB_CORES-1:0];

  assign ack_keep = core_irq_ack_i ? ~(`EU_DATA_W'(1) << core_irq_ack_id_i) : '1;

  // clears first, then new lines, then the acknowledged bit
  always_comb begin
    buffer_d = buffer_q;
    if (op_i.fire && op_i.op == eu_pkg::OP_BUF_CLEAR) begin
      buffer_d = buffer_q & ~op_i.wdata;
    end else if (op_i.fire && op_i.op == eu_pkg::OP_WAIT_CLEAR) begin
      buffer_d = buffer_q & ~evt_mask_q;
    end
    buffer_d = (buffer_d | evt_lines_i) & ack_keep;
  end

  // highest pending interrupt wins
  always_comb begin
    core_irq_id_o = '0;
    for (int i = 0; i < `EU_DATA_W; i++) begin
      if (irq_masked[i]) begin
        core_irq_id_o = i[`EU_IRQ_ID_W-1:0];
      end
    end
  end

  always_comb begin
    op_i.rdata = '0;
    if (op_i.op inside {eu_pkg::OP_READ, eu_pkg::OP_WAIT, eu_pkg::OP_WAIT_CLEAR}) begin
      case (op_i.reg_sel)
        eu_pkg::REG_EVT_MASK:          op_i.rdata = evt_mask_q;
        eu_pkg::REG_IRQ_MASK:          op_i.rdata = irq_mask_q;
        eu_pkg::REG_EVT_BUFFER:        op_i.rdata = buffer_q;
        eu_pkg::REG_EVT_BUFFER_MASKED: op_i.rdata = evt_masked;
        eu_pkg::REG_EVT_BUFFER_IRQ:    op_i.rdata = irq_masked;
        eu_pkg::REG_SW_EVT_MASK:       op_i.rdata = `EU_DATA_W'(sw_mask_q);
        eu_pkg::REG_EVT_WAIT,
        eu_pkg::REG_EVT_WAIT_CLEAR:    op_i.rdata = evt_masked;
        default:                       op_i.rdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_mask_q    <= '0;
      irq_mask_q    <= '0;
      buffer_q      <= '0;
      sw_mask_q     <= '0;
      irq_req_q     <= 1'b0;
      sw_evt_q      <= '0;
      sw_evt_mask_q <= '0;
    end else begin
      if (evt_mask_we) begin
        evt_mask_q <= mask_upd(evt_mask_q, op_i.wdata, op_i.op);
      end
      if (irq_mask_we) begin
        irq_mask_q <= mask_upd(irq_mask_q, op_i.wdata, op_i.op);
      end
      if (op_i.fire && op_i.op == eu_pkg::OP_WRITE &&
          op_i.reg_sel == eu_pkg::REG_SW_EVT_MASK) begin
        sw_mask_q <= op_i.wdata[`EU_NB_CORES-1:0];
      end
      buffer_q  <= buffer_d;
      irq_req_q <= irq_pending_o;

      // one cycle pulse toward the addressed cores
      sw_evt_q      <= '0;
      sw_evt_mask_q <= '0;
      if (sw_trig) begin
        sw_evt_q[op_i.sw_idx] <= 1'b1;
        sw_evt_mask_q         <= trig_cores;
      end
    end
  end

  assign core_irq_req_o        = irq_req_q;
  assign core_sw_events_o      = sw_evt_q;
  assign core_sw_events_mask_o = sw_evt_mask_q;

endmodule

// ==== hw/eu_core/eu_clock_ctrl.sv ====
// ----------------------------------------------------------
// core clock controller
// gates the core clock while a wait is held back
// ----------------------------------------------------------

module eu_clock_ctrl (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic wait_blocked_i,
  input  logic evt_pending_i,
  input  logic irq_pending_i,
  input  logic core_busy_i,

  output logic core_clock_en_o
);

  eu_pkg::eu_sleep_e state_q;
  eu_pkg::eu_sleep_e state_d;

  always_comb begin
    state_d         = state_q;
    core_clock_en_o = 1'b1;

    case (state_q)
      eu_pkg::AWAKE: begin
        // core idle on a held wait with nothing to wake it
        if (wait_blocked_i && !irq_pending_i && !evt_pending_i && !core_busy_i) begin
          state_d = eu_pkg::ASLEEP;
        end
      end
      eu_pkg::ASLEEP: begin
        core_clock_en_o = 1'b0;
        // release without waiting for the edge
        if (evt_pending_i || irq_pending_i) begin
          core_clock_en_o = 1'b1;
          state_d         = eu_pkg::AWAKE;
        end
      end
      default: begin
        state_d = eu_pkg::AWAKE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= eu_pkg::AWAKE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== hw/eu_core/eu_read_resp.sv ====
// ----------------------------------------------------------
// response stage
// one-entry response register with valid/ready back-pressure
// ----------------------------------------------------------

`include "eu_params.svh"

module eu_read_resp (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  eu_op_if.res                  op_i,

  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output logic [`EU_DATA_W-1:0] rsp_rdata_o,

  output logic                  resp_busy_o
);

  logic                  valid_q;
  logic [`EU_DATA_W-1:0] rdata_q;

  // a new accept only happens once the old response leaves
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (op_i.fire) begin
      valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (op_i.fire) begin
      rdata_q <= op_i.rdata;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_rdata_o = rdata_q;

  // full and not drained this cycle
  assign resp_busy_o = valid_q & ~rsp_ready_i;

endmodule

// ==== hw/eu_core/eu_core_top.sv ====
// ----------------------------------------------------------
// event unit core top level
// ----------------------------------------------------------

`include "eu_params.svh"

module eu_core_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // register port
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  logic [`EU_ADDR_W-1:0]    req_addr_i,
  input  logic                     req_we_i,
  input  logic [`EU_DATA_W-1:0]    req_wdata_i,
  output logic                     rsp_valid_o,
  input  logic                     rsp_ready_i,
  output logic [`EU_DATA_W-1:0]    rsp_rdata_o,

  // event lines and core side
  input  logic [`EU_DATA_W-1:0]    evt_lines_i,
  output logic                     core_irq_req_o,
  output logic [`EU_IRQ_ID_W-1:0]  core_irq_id_o,
  input  logic                     core_irq_ack_i,
  input  logic [`EU_IRQ_ID_W-1:0]  core_irq_ack_id_i,
  input  logic                     core_busy_i,
  output logic                     core_clock_en_o,

  // software events toward other cores
  output logic [`EU_NB_SW_EVT-1:0] core_sw_events_o,
  output logic [`EU_NB_CORES-1:0]  core_sw_events_mask_o
);

  logic evt_pending;
  logic irq_pending;
  logic wait_blocked;
  logic resp_busy;

  eu_op_if op_link ();

  eu_req_decode u_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_addr_i     (req_addr_i),
    .req_we_i       (req_we_i),
    .req_wdata_i    (req_wdata_i),
    .evt_pending_i  (evt_pending),
    .irq_pending_i  (irq_pending),
    .resp_busy_i    (resp_busy),
    .wait_blocked_o (wait_blocked),
    .op_o           (op_link.dec)
  );

  eu_event_regs u_regs (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .evt_lines_i           (evt_lines_i),
    .core_irq_ack_i        (core_irq_ack_i),
    .core_irq_ack_id_i     (core_irq_ack_id_i),
    .op_i                  (op_link.exe),
    .evt_pending_o         (evt_pending),
    .irq_pending_o         (irq_pending),
    .core_irq_req_o        (core_irq_req_o),
    .core_irq_id_o         (core_irq_id_o),
    .core_sw_events_o      (core_sw_events_o),
    .core_sw_events_mask_o (core_sw_events_mask_o)
  );

  eu_clock_ctrl u_clock (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wait_blocked_i  (wait_blocked),
    .evt_pending_i   (evt_pending),
    .irq_pending_i   (irq_pending),
    .core_busy_i     (core_busy_i),
    .core_clock_en_o (core_clock_en_o)
  );

  eu_read_resp u_resp (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op_i        (op_link.res),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .resp_busy_o (resp_busy)
  );

endmodule

// ==== tb/tb_eu_core.sv ====
// ----------------------------------------------------------
// event unit testbench
// table driven register, interrupt, software event and wait tests
// ----------------------------------------------------------

`include "eu_params.svh"

module tb_eu_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int K_ACC  = 0;
  localparam int K_EVT  = 1;
  localparam int K_ACK  = 2;
  localparam int K_IRQ  = 3;
  localparam int K_SWT  = 4;
  localparam int K_WAIT = 5;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     req_valid_i;
  logic                     req_ready_o;
  logic [`EU_ADDR_W-1:0]    req_addr_i;
  logic                     req_we_i;
  logic [`EU_DATA_W-1:0]    req_wdata_i;
  logic                     rsp_valid_o;
  logic                     rsp_ready_i = 1'b1;
  logic [`EU_DATA_W-1:0]    rsp_rdata_o;
  logic [`EU_DATA_W-1:0]    evt_lines_i;
  logic                     core_irq_req_o;
  logic [`EU_IRQ_ID_W-1:0]  core_irq_id_o;
  logic                     core_irq_ack_i;
  logic [`EU_IRQ_ID_W-1:0]  core_irq_ack_id_i;
  logic                     core_busy_i;
  logic                     core_clock_en_o;
  logic [`EU_NB_SW_EVT-1:0] core_sw_events_o;
  logic [`EU_NB_CORES-1:0]  core_sw_events_mask_o;

  // stimulus table, one entry per index
  string                 t_name[$];
  int                    t_kind[$];
  logic [`EU_ADDR_W-1:0] t_addr[$];
  logic                  t_we[$];
  logic [`EU_DATA_W-1:0] t_wdata[$];
  logic [`EU_DATA_W-1:0] t_evt[$];
  logic [`EU_DATA_W-1:0] t_exp[$];

  int err_cnt     = 0;
  int test_cnt    = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;
  int acc_cnt     = 0;
  int rsp_cnt     = 0;
  int held_cnt    = 0;
  bit bp_on       = 1'b0;
  bit hold_rsp    = 1'b0;

  eu_core_top u_dut (.*);

  always #20 clk_i = ~clk_i;

  // random response back-pressure in the second pass, or a forced stall
  always @(posedge clk_i) begin
    logic [31:0] rnd;
    rnd = $urandom;
    rsp_ready_i <= hold_rsp ? 1'b0 : (bp_on ? rnd[0] : 1'b1);
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  // handshake monitor, inputs are stable around the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (req_valid_i && req_ready_o) acc_cnt++;
      if (rsp_valid_o && rsp_ready_i) rsp_cnt++;
      if (req_valid_i && req_ready_o && rsp_valid_o && !rsp_ready_i) begin
        $display("a request was accepted while a response was held");
        held_cnt++;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic add_entry(input string name, input int kind, input logic [4:0] addr,
                           input logic we, input logic [31:0] wdata,
                           input logic [31:0] evt, input logic [31:0] exp);
    t_name.push_back(name);
    t_kind.push_back(kind);
    t_addr.push_back(addr);
    t_we.push_back(we);
    t_wdata.push_back(wdata);
    t_evt.push_back(evt);
    t_exp.push_back(exp);
  endtask

  // irq checks expect {req, 3'b0, id}, trigger checks {sw events, core mask}
  task automatic build_table();
    add_entry("evt_mask_write", K_ACC, 5'd0, 1'b1, 32'h0000_f0f0, '0, '0);
    add_entry("evt_mask_and", K_ACC, 5'd1, 1'b1, 32'h0000_00f0, '0, '0);
    add_entry("evt_mask_or", K_ACC, 5'd2, 1'b1, 32'h0000_0013, '0, '0);
    add_entry("evt_mask_read", K_ACC, 5'd0, 1'b0, '0, '0, 32'h0000_f013);
    add_entry("irq_mask_write", K_ACC, 5'd3, 1'b1, 32'hffff_0000, '0, '0);
    add_entry("irq_mask_and", K_ACC, 5'd4, 1'b1, 32'hffff_0000, '0, '0);
    add_entry("irq_mask_or", K_ACC, 5'd5, 1'b1, 32'h0000_0208, '0, '0);
    add_entry("irq_mask_read", K_ACC, 5'd3, 1'b0, '0, '0, 32'h0000_0208);
    add_entry("sw_mask_write", K_ACC, 5'd11, 1'b1, 32'h0000_0abc, '0, '0);
    add_entry("sw_mask_read", K_ACC, 5'd11, 1'b0, '0, '0, 32'h0000_000c);
    add_entry("evt_lines_pulse", K_EVT, '0, 1'b0, '0, 32'h0001_1002, '0);
    add_entry("buffer_read", K_ACC, 5'd7, 1'b0, '0, '0, 32'h0001_1002);
    add_entry("buffer_evt_masked", K_ACC, 5'd8, 1'b0, '0, '0, 32'h0000_1002);
    add_entry("buffer_irq_masked", K_ACC, 5'd9, 1'b0, '0, '0, 32'h0000_0000);
    add_entry("buffer_clear", K_ACC, 5'd10, 1'b1, 32'h0001_0002, '0, '0);
    add_entry("buffer_after_clear", K_ACC, 5'd7, 1'b0, '0, '0, 32'h0000_1000);
    add_entry("irq_lines_pulse", K_EVT, '0, 1'b0, '0, 32'h0000_0208, '0);
    add_entry("irq_highest", K_IRQ, '0, 1'b0, '0, '0, 32'h0000_0109);
    add_entry("buffer_irq_pending", K_ACC, 5'd9, 1'b0, '0, '0, 32'h0000_0208);
    add_entry("irq_ack_9", K_ACK, '0, 1'b0, 32'd9, '0, '0);
    add_entry("irq_next", K_IRQ, '0, 1'b0, '0, '0, 32'h0000_0103);
    add_entry("irq_ack_3", K_ACK, '0, 1'b0, 32'd3, '0, '0);
    add_entry("irq_dropped", K_IRQ, '0, 1'b0, '0, '0, 32'h0000_0000);
    add_entry("sw_trig_2", K_SWT, 5'd18, 1'b1, 32'h0000_0005, '0, 32'h0000_0045);
    add_entry("sw_trig_7_all", K_SWT, 5'd23, 1'b1, 32'h0000_0010, '0, 32'h0000_080f);
    add_entry("buffer_clear_all", K_ACC, 5'd10, 1'b1, 32'hffff_ffff, '0, '0);
    add_entry("wait_clear_sleep", K_WAIT, 5'd15, 1'b0, '0, 32'h0002_0010, 32'h0000_0010);
    add_entry("masked_after_wait", K_ACC, 5'd8, 1'b0, '0, '0, 32'h0000_0000);
    add_entry("buffer_after_wait", K_ACC, 5'd7, 1'b0, '0, '0, 32'h0002_0000);
    add_entry("evt_line_15", K_EVT, '0, 1'b0, '0, 32'h0000_8000, '0);
    add_entry("wait_pending", K_ACC, 5'd14, 1'b0, '0, '0, 32'h0000_8000);
    add_entry("masked_kept", K_ACC, 5'd8, 1'b0, '0, '0, 32'h0000_8000);
  endtask

  task automatic apply_reset(input bit bp);
    rst_ni            <= 1'b0;
    req_valid_i       <= 1'b0;
    req_addr_i        <= '0;
    req_we_i          <= 1'b0;
    req_wdata_i       <= '0;
    evt_lines_i       <= '0;
    core_irq_ack_i    <= 1'b0;
    core_irq_ack_id_i <= '0;
    core_busy_i       <= 1'b0;
    bp_on             <= bp;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
  endtask

  task automatic await_accept(input string name, input bit clock_check);
    bit acc;
    bit first;
    acc   = 1'b0;
    first = 1'b1;
    while (!acc) begin
      @(negedge clk_i);
      if (first && clock_check) begin
        check_value({name, " clock released"}, 32'd1, 32'(core_clock_en_o));
      end
      first = 1'b0;
      acc   = req_ready_o;
      @(posedge clk_i);
    end
    req_valid_i <= 1'b0;
  endtask

  // response must be up the cycle after acceptance and be taken once
  task automatic collect_rsp(input string name, output logic [31:0] rdata,
                             output logic [31:0] sw_first, output logic [31:0] sw_second);
    bit got;
    @(negedge clk_i);
    check_value({name, " rsp timing"}, 32'd1, 32'(rsp_valid_o));
    sw_first = 32'({core_sw_events_o, core_sw_events_mask_o});
    got      = rsp_valid_o && rsp_ready_i;
    rdata    = rsp_rdata_o;
    @(posedge clk_i);
    @(negedge clk_i);
    sw_second = 32'({core_sw_events_o, core_sw_events_mask_o});
    if (got) begin
      check_value({name, " single rsp"}, 32'd0, 32'(rsp_valid_o));
    end else begin
      got   = rsp_valid_o && rsp_ready_i;
      rdata = rsp_rdata_o;
    end
    @(posedge clk_i);
    while (!got) begin
      @(negedge clk_i);
      got   = rsp_valid_o && rsp_ready_i;
      rdata = rsp_rdata_o;
      @(posedge clk_i);
    end
  endtask

  task automatic pulse_lines(input logic [31:0] lines);
    evt_lines_i <= lines;
    @(posedge clk_i);
    evt_lines_i <= '0;
    repeat (2) @(posedge clk_i);
  endtask

  task automatic ack_irq(input logic [4:0] id);
    core_irq_ack_i    <= 1'b1;
    core_irq_ack_id_i <= id;
    @(posedge clk_i);
    core_irq_ack_i <= 1'b0;
    repeat (2) @(posedge clk_i);
  endtask

  task automatic run_wait(input int i);
    logic [31:0] rdata;
    logic [31:0] sw_a;
    logic [31:0] sw_b;
    req_addr_i  <= t_addr[i];
    req_we_i    <= 1'b0;
    req_valid_i <= 1'b1;
    repeat (4) begin
      @(negedge clk_i);
      if (req_ready_o || rsp_valid_o) begin
        $display("%s: the wait went through with no masked event pending", t_name[i]);
        err_cnt++;
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    check_value({t_name[i], " clock gated"}, 32'd0, 32'(core_clock_en_o));
    @(posedge clk_i);
    // the wait must be taken in the cycle the masked line lands in the buffer
    evt_lines_i <= t_evt[i];
    @(posedge clk_i);
    evt_lines_i <= '0;
    await_accept(t_name[i], 1'b1);
    collect_rsp(t_name[i], rdata, sw_a, sw_b);
    check_value(t_name[i], t_exp[i], rdata);
  endtask

  // a read behind a held response must stall, both answers come back in order
  task automatic probe_held_rsp(input string tag);
    logic [31:0] rdata;
    logic [31:0] sw_a;
    logic [31:0] sw_b;
    bit          got;
    bit          taken;
    int          errs_before;
    errs_before = err_cnt;
    got         = 1'b0;
    taken       = 1'b0;
    hold_rsp   <= 1'b1;
    @(posedge clk_i);
    req_addr_i  <= 5'd0;
    req_we_i    <= 1'b0;
    req_valid_i <= 1'b1;
    await_accept("held_rsp", 1'b0);
    req_addr_i  <= 5'd11;
    req_valid_i <= 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_value("held_rsp kept", 32'd1, 32'(rsp_valid_o));
      check_value("held_rsp stall", 32'd0, 32'(req_ready_o));
      @(posedge clk_i);
    end
    hold_rsp <= 1'b0;
    while (!got) begin
      @(negedge clk_i);
      got   = rsp_valid_o && rsp_ready_i;
      taken = taken || (req_valid_i && req_ready_o);
      rdata = rsp_rdata_o;
      @(posedge clk_i);
      if (taken) begin
        req_valid_i <= 1'b0;
      end
    end
    // mask values left behind by the table
    check_value("held_rsp first", 32'h0000_f013, rdata);
    if (!taken) begin
      await_accept("held_rsp", 1'b0);
    end
    collect_rsp("held_rsp", rdata, sw_a, sw_b);
    check_value("held_rsp second", 32'h0000_000c, rdata);
    test_cnt++;
    $display("[%s] held_rsp: %s", tag, (err_cnt == errs_before) ? "pass" : "fail");
  endtask

  task automatic run_table(input string tag);
    logic [31:0] rdata;
    logic [31:0] sw_a;
    logic [31:0] sw_b;
    logic [31:0] got;
    int          errs_before;
    for (int i = 0; i < t_name.size(); i++) begin
      errs_before = err_cnt;
      case (t_kind[i])
        K_ACC, K_SWT: begin
          req_addr_i  <= t_addr[i];
          req_we_i    <= t_we[i];
          req_wdata_i <= t_wdata[i];
          req_valid_i <= 1'b1;
          await_accept(t_name[i], 1'b0);
          collect_rsp(t_name[i], rdata, sw_a, sw_b);
          if (t_kind[i] == K_SWT) begin
            check_value(t_name[i], t_exp[i], sw_a);
            check_value({t_name[i], " pulse end"}, 32'd0, sw_b);
          end else if (!t_we[i]) begin
            check_value(t_name[i], t_exp[i], rdata);
          end
        end
        K_EVT: pulse_lines(t_evt[i]);
        K_ACK: ack_irq(t_wdata[i][4:0]);
        K_IRQ: begin
          @(negedge clk_i);
          got = 32'({core_irq_req_o, 3'b000, core_irq_id_o});
          // with no request pending only the request line matters
          if (t_exp[i][8]) begin
            check_value(t_name[i], t_exp[i], got);
          end else begin
            check_value(t_name[i], 32'd0, 32'(core_irq_req_o));
          end
          @(posedge clk_i);
        end
        K_WAIT: run_wait(i);
        default: begin
        end
      endcase
      test_cnt++;
      $display("[%s] %s: %s", tag, t_name[i], (err_cnt == errs_before) ? "pass" : "fail");
    end
  endtask

  initial begin
    void'($urandom(64));
    build_table();
    cycle_limit = 40 * 2 * t_name.size() + 200;
    apply_reset(1'b0);
    run_table("ready");
    apply_reset(1'b1);
    run_table("backpressure");
    probe_held_rsp("backpressure");
    check_value("accepts vs responses", 32'(acc_cnt), 32'(rsp_cnt));
    check_value("accepts while response held", 32'd0, 32'(held_cnt));
    $display("%0d tests, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+common
common/eu_pkg.sv
common/eu_op_if.sv
hw/eu_core/eu_req_decode.sv
hw/eu_core/eu_event_regs.sv
hw/eu_core/eu_clock_ctrl.sv
hw/eu_core/eu_read_resp.sv
hw/eu_core/eu_core_top.sv
tb/tb_eu_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the event unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  -f filelist.f --top-module tb_eu_core -o tb_eu_core

./obj_dir/tb_eu_core > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation finished"
